// ==== verilog/frontEnd_macros.svh ====
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// Program image size in 32-bit words
`define PROG_WORDS 32

// Issue queue entries, a power of two
`define QUEUE_DEPTH 4

// Credits the consumer grants out of reset
`define CREDITS 4

// Unconditional relative branch
`define OP_BRANCH 7'b1100000

// No operation, dropped by the expander
`define OP_NOP 7'b1100100

// Micro-operation opcodes start here, slot a maps to UOP_BASE + a
`define UOP_BASE 7'b1000000

`endif

// ==== verilog/isaPkg.sv ====
`default_nettype none

package isaPkg;

    // Raw instruction and its fields
    typedef logic [31:0] instrWord;
    typedef logic [6:0]  opcodeT;
    typedef logic [3:0]  regIdx;
    typedef logic [15:0] imm16;

    // Byte address into program memory
    typedef logic [31:0] pcWord;

    // Microcode ROM slot index
    typedef logic [3:0]  ucodeAddr;

    function automatic opcodeT opcodeOf(instrWord w);
        return w[31:25];
    endfunction

    function automatic regIdx rdOf(instrWord w);
        return w[24:21];
    endfunction

    function automatic regIdx rsOf(instrWord w);
        return w[20:17];
    endfunction

    function automatic imm16 immOf(instrWord w);
        return w[15:0];
    endfunction

    // Immediate widened to an address offset
    function automatic pcWord immSext(instrWord w);
        return {{16{w[15]}}, w[15:0]};
    endfunction

endpackage

`default_nettype wire

// ==== verilog/frontCtlPkg.sv ====
`include "frontEnd_macros.svh"

`default_nettype none

package frontCtlPkg;

    // Expander mode
    typedef enum logic {
        sPass,
        sUcode
    } expState;

    // Sized to hold the full grant
    typedef logic [$clog2(`CREDITS + 1) - 1:0] creditCnt;

    // Sized to hold a full queue
    typedef logic [$clog2(`QUEUE_DEPTH + 1) - 1:0] queueCnt;

endpackage

`default_nettype wire

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ps

`include "frontEnd_macros.svh"

`default_nettype none

module fetchStage
    import isaPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     fetchStall,
    output logic     fetchValid,
    output instrWord fetchInstr
);

    localparam int addrBits = $clog2(`PROG_WORDS);

    // First byte address past the program
    localparam pcWord endPc = pcWord'(`PROG_WORDS * 4);

    instrWord progMem [`PROG_WORDS];

    pcWord    pc;
    pcWord    nextPc;
    instrWord curWord;
    logic     done;

    initial begin
        $readmemh("verification/program.hex", progMem);
    end

    // Word addressed by the PC
    assign curWord = progMem[pc[addrBits + 1:2]];

    // Branch target is relative to the address after the branch
    always_comb begin
        if (opcodeOf(curWord) == `OP_BRANCH) begin
            nextPc = pc + 32'd4 + immSext(curWord);
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            done       <= 1'b0;
            fetchValid <= 1'b0;
        end else if (!fetchStall) begin
            fetchValid <= !done;
            if (!done) begin
                pc   <= nextPc;
                // Branches go forward only, so leaving the image ends the program
                done <= nextPc >= endPc;
            end
        end
    end

    // Presented word
    always_ff @(posedge clk) begin
        if (!fetchStall && !done) begin
            fetchInstr <= curWord;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ucodeExpander.sv ====
`timescale 1ns/1ps

`include "frontEnd_macros.svh"

`default_nettype none

module ucodeExpander
    import isaPkg::*;
    import frontCtlPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     fetchValid,
    input  instrWord fetchInstr,
    output logic     fetchStall,
    input  logic     expStall,
    output logic     expValid,
    output instrWord expInstr,
    output logic     expIsUcode
);

    localparam opcodeT uopBase = `UOP_BASE;

    expState    state;
    ucodeAddr   uBase;
    logic [2:0] uStep;

    // Fields of the multiply being expanded
    regIdx      mulRd;
    regIdx      mulRs;
    logic       mulBit16;
    imm16       mulImm;

    opcodeT     inOp;
    logic       isNop;
    logic       isMul;
    logic [1:0] mulVar;
    logic [4:0] romSlot;
    logic [7:0] romWord;
    logic       romLast;
    opcodeT     romOp;

    // Last flag in bit 7, opcode below it
    // Variant 3 runs into slot 16, one past the 4k grid
    function automatic logic [7:0] ucodeRom(logic [4:0] slot);
        case (slot)
            5'd0:    return {1'b0, uopBase + 7'd0};
            5'd1:    return {1'b1, uopBase + 7'd1};
            5'd4:    return {1'b0, uopBase + 7'd4};
            5'd5:    return {1'b0, uopBase + 7'd5};
            5'd6:    return {1'b1, uopBase + 7'd6};
            5'd8:    return {1'b0, uopBase + 7'd8};
            5'd9:    return {1'b0, uopBase + 7'd9};
            5'd10:   return {1'b0, uopBase + 7'd10};
            5'd11:   return {1'b1, uopBase + 7'd11};
            5'd12:   return {1'b0, uopBase + 7'd12};
            5'd13:   return {1'b0, uopBase + 7'd13};
            5'd14:   return {1'b0, uopBase + 7'd14};
            5'd15:   return {1'b0, uopBase + 7'd15};
            5'd16:   return {1'b1, uopBase + 7'd16};
            // Unused slots end a sequence at once
            default: return {1'b1, uopBase};
        endcase
    endfunction

    // Decode of the presented word
    assign inOp   = opcodeOf(fetchInstr);
    assign isNop  = inOp == `OP_NOP;
    assign isMul  = inOp inside {7'b0010000, 7'b0011000, 7'b0110000, 7'b0111000};
    assign mulVar = {inOp[5], inOp[3]};

    // Sequencer ROM lookup
    assign romSlot = {1'b0, uBase} + {2'b00, uStep};
    assign romWord = ucodeRom(romSlot);
    assign romLast = romWord[7];
    assign romOp   = romWord[6:0];

    // Fetch waits while a sequence plays out
    assign fetchStall = (state == sUcode) || expStall;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= sPass;
            uStep    <= '0;
            expValid <= 1'b0;
        end else if (!expStall) begin
            case (state)
                sPass: begin
                    expValid <= fetchValid && !isNop && !isMul;
                    if (fetchValid && isMul) begin
                        state <= sUcode;
                        uStep <= '0;
                    end
                end
                sUcode: begin
                    expValid <= 1'b1;
                    uStep    <= uStep + 3'd1;
                    if (romLast) begin
                        state <= sPass;
                    end
                end
                default: begin
                    state <= sPass;
                end
            endcase
        end
    end

    // Output word and multiply fields
    always_ff @(posedge clk) begin
        if (!expStall) begin
            if (state == sPass) begin
                expInstr   <= fetchInstr;
                expIsUcode <= 1'b0;
                if (fetchValid && isMul) begin
                    uBase    <= {mulVar, 2'b00};
                    mulRd    <= rdOf(fetchInstr);
                    mulRs    <= rsOf(fetchInstr);
                    mulBit16 <= fetchInstr[16];
                    mulImm   <= immOf(fetchInstr);
                end
            end else begin
                expInstr   <= {romOp, mulRd, mulRs, mulBit16, mulImm};
                expIsUcode <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/creditIssue.sv ====
`timescale 1ns/1ps

`include "frontEnd_macros.svh"

`default_nettype none

module creditIssue
    import isaPkg::*;
    import frontCtlPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     expValid,
    input  instrWord expInstr,
    input  logic     expIsUcode,
    output logic     expStall,
    input  logic     creditReturn,
    output logic     instrValid,
    output instrWord instrOut,
    output logic     isUcode
);

    localparam int ptrBits = $clog2(`QUEUE_DEPTH);

    // Queue storage
    instrWord qWord  [`QUEUE_DEPTH];
    logic     qUcode [`QUEUE_DEPTH];

    // Pointers wrap naturally at the power-of-two depth
    logic [ptrBits - 1:0] wrPtr;
    logic [ptrBits - 1:0] rdPtr;

    queueCnt  count;
    creditCnt credits;
    logic     push;
    logic     pop;

    assign expStall = count == queueCnt'(`QUEUE_DEPTH);
    assign push     = expValid && !expStall;

    // Issue needs a queued word and a credit to spend
    assign pop = (count != '0) && (credits != '0);

    // Head of queue goes straight out
    assign instrValid = pop;
    assign instrOut   = qWord[rdPtr];
    assign isUcode    = qUcode[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            credits <= creditCnt'(`CREDITS);
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count   <= count + queueCnt'(push) - queueCnt'(pop);
            // A return and a spend in one cycle cancel out
            credits <= credits + creditCnt'(creditReturn) - creditCnt'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            qWord[wrPtr]  <= expInstr;
            qUcode[wrPtr] <= expIsUcode;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/frontEnd.sv ====
`timescale 1ns/1ps

`default_nettype none

module frontEnd
    import isaPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     creditReturn,
    output logic     instrValid,
    output instrWord instrOut,
    output logic     isUcode
);

    // Fetch to expander
    logic     fetchValid;
    instrWord fetchInstr;
    logic     fetchStall;

    // Expander to issue queue
    logic     expValid;
    instrWord expInstr;
    logic     expIsUcode;
    logic     expStall;

    fetchStage i_fetchStage (
        .clk        (clk),
        .rst        (rst),
        .fetchStall (fetchStall),
        .fetchValid (fetchValid),
        .fetchInstr (fetchInstr)
    );

    ucodeExpander i_ucodeExpander (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchInstr (fetchInstr),
        .fetchStall (fetchStall),
        .expStall   (expStall),
        .expValid   (expValid),
        .expInstr   (expInstr),
        .expIsUcode (expIsUcode)
    );

    // Only stage that sees credits
    creditIssue i_creditIssue (
        .clk          (clk),
        .rst          (rst),
        .expValid     (expValid),
        .expInstr     (expInstr),
        .expIsUcode   (expIsUcode),
        .expStall     (expStall),
        .creditReturn (creditReturn),
        .instrValid   (instrValid),
        .instrOut     (instrOut),
        .isUcode      (isUcode)
    );

endmodule

`default_nettype wire

// ==== verification/frontEnd_sva.sv ====
`timescale 1ns/1ps

`include "frontEnd_macros.svh"

`default_nettype none

module frontEnd_sva
    import isaPkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     creditReturn,
    input logic     instrValid,
    input logic     expValid,
    input logic     expStall,
    input instrWord expInstr,
    input logic     expIsUcode
);

    int violations = 0;

    // Words the consumer holds, counted from the port handshake alone
    int inFlight;

    always_ff @(posedge clk) begin
        if (rst) begin
            inFlight <= 0;
        end else begin
            inFlight <= inFlight + int'(instrValid) - int'(creditReturn);
        end
    end

    // A word leaves only while a credit is held
    creditSpend: assert property (@(posedge clk) disable iff (rst)
        instrValid |-> inFlight < `CREDITS)
        else begin
            $error("instrValid high with zero credits");
            violations++;
        end

    resetQuiet: assert property (@(posedge clk) rst |=> !expValid)
        else begin
            $error("expValid high during reset");
            violations++;
        end

    // Full queue freezes the expander outputs
    stallHold: assert property (@(posedge clk) disable iff (rst)
        expStall |=> $stable(expValid) && $stable(expInstr) && $stable(expIsUcode))
        else begin
            $error("expander outputs changed under expStall");
            violations++;
        end

endmodule

bind creditIssue frontEnd_sva i_sva (
    .clk          (clk),
    .rst          (rst),
    .creditReturn (creditReturn),
    .instrValid   (instrValid),
    .expValid     (expValid),
    .expStall     (expStall),
    .expInstr     (expInstr),
    .expIsUcode   (expIsUcode)
);

`default_nettype wire

// ==== verification/frontEnd_tb.sv ====
`timescale 1ns/1ps

`include "frontEnd_macros.svh"

`default_nettype none

module frontEnd_tb
    import isaPkg::*;
();

    localparam int timeoutCycles = 2000;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    logic     creditReturn = 1'b0;
    logic     instrValid;
    instrWord instrOut;
    logic     isUcode;

    // Expected output stream, built from the program image
    instrWord progImage [`PROG_WORDS];
    instrWord expWords [$];
    logic     expUcode [$];

    logic [15:0] lfsr = 16'd52512;
    logic        holdCredits = 1'b1;
    int          dueCnt [16];
    int          readyCredits;
    int          cycle;
    int          rxCount = 0;
    int          errors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    always #2 clk = ~clk;

    frontEnd i_frontEnd (
        .clk          (clk),
        .rst          (rst),
        .creditReturn (creditReturn),
        .instrValid   (instrValid),
        .instrOut     (instrOut),
        .isUcode      (isUcode)
    );

    // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int drawBits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsrNext(lfsr);
        end
        return v;
    endfunction

    // Walk the program from address 0 and list every word the consumer must see
    function automatic void buildExpected();
        pcWord      pc;
        instrWord   w;
        logic [6:0] op;
        int         k;
        pc = '0;
        while (pc < `PROG_WORDS * 4) begin
            w  = progImage[pc / 4];
            op = w[31:25];
            if (op inside {7'b0010000, 7'b0011000, 7'b0110000, 7'b0111000}) begin
                k = {op[5], op[3]};
                for (int i = 0; i < k + 2; i++) begin
                    expWords.push_back({7'(`UOP_BASE + 4 * k + i), w[24:0]});
                    expUcode.push_back(1'b1);
                end
            end else if (op != `OP_NOP) begin
                expWords.push_back(w);
                expUcode.push_back(1'b0);
            end
            if (op == `OP_BRANCH) begin
                pc = pc + 32'd4 + {{16{w[15]}}, w[15:0]};
            end else begin
                pc = pc + 32'd4;
            end
        end
    endfunction

    task automatic reportTest(string name, int failures);
        testsRun++;
        if (failures == 0) begin
            $display("PASS  %s", name);
        end else begin
            $display("FAIL  %s (%0d errors)", name, failures);
            testsFailed++;
        end
    endtask

    // Consumer returns one credit per delivery after 0 to 7 cycles
    always @(posedge clk) begin
        int slot;
        if (rst) begin
            creditReturn <= 1'b0;
            readyCredits = 0;
            cycle = 0;
            for (int i = 0; i < 16; i++) begin
                dueCnt[i] = 0;
            end
        end else begin
            cycle = cycle + 1;
            if (instrValid) begin
                slot = (cycle + drawBits(3)) % 16;
                dueCnt[slot] = dueCnt[slot] + 1;
            end
            readyCredits = readyCredits + dueCnt[cycle % 16];
            dueCnt[cycle % 16] = 0;
            // At most one return per cycle
            if (!holdCredits && readyCredits > 0) begin
                creditReturn <= 1'b1;
                readyCredits = readyCredits - 1;
            end else begin
                creditReturn <= 1'b0;
            end
        end
    end

    // Compare each delivery with the next expected entry
    always @(posedge clk) begin
        if (!rst && instrValid) begin
            if (rxCount >= expWords.size()) begin
                $display("Extra word %h delivered at %0t past the end of the stream",
                         instrOut, $time);
                errors++;
            end else begin
                if (instrOut !== expWords[rxCount]) begin
                    $display("** Error at %0t: instrOut = %h, expected %h",
                             $time, instrOut, expWords[rxCount]);
                    errors++;
                end
                if (isUcode !== expUcode[rxCount]) begin
                    $display("** Error at %0t: isUcode = %b, expected %b",
                             $time, isUcode, expUcode[rxCount]);
                    errors++;
                end
            end
            rxCount++;
        end
    end

    initial begin
        int fails;
        int seen;
        int waitCycles;
        $readmemh("verification/program.hex", progImage);
        buildExpected();
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Credits withheld, so only the initial grant may leave
        fails = errors;
        repeat (40) @(negedge clk);
        if (rxCount > `CREDITS) begin
            $display("Credit hold: %0d words delivered with %0d credits granted",
                     rxCount, `CREDITS);
            fails--;
        end
        reportTest("credit hold", errors - fails);
        holdCredits = 1'b0;

        fails = errors;
        waitCycles = 0;
        while (rxCount < expWords.size() && waitCycles < timeoutCycles) begin
            @(negedge clk);
            waitCycles++;
        end
        if (rxCount < expWords.size()) begin
            $display("Timeout: %0d of %0d words arrived", rxCount, expWords.size());
            fails--;
        end
        reportTest("instruction stream", errors - fails);

        fails = errors;
        seen = rxCount;
        repeat (50) @(negedge clk);
        if (rxCount != seen) begin
            $display("Quiet end: %0d words arrived after the stream ended", rxCount - seen);
            fails--;
        end
        reportTest("quiet end", errors - fails);

        reportTest("assertions", i_frontEnd.i_creditIssue.i_sva.violations);

        $display("Summary: %0d tests, %0d failing, %0d mismatches, %0d of %0d words",
                 testsRun, testsFailed, errors, rxCount, expWords.size());
        if (errors == 0 && testsFailed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/isaPkg.sv
verilog/frontCtlPkg.sv
verilog/fetchStage.sv
verilog/ucodeExpander.sv
verilog/creditIssue.sv
verilog/frontEnd.sv
verification/frontEnd_sva.sv
verification/frontEnd_tb.sv

// ==== Makefile ====
TOP = frontEnd_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// ==== verification/program.hex ====
// One 32-bit instruction word per line, word address 0 first
// Fields: opcode[31:25] rd[24:21] rs[20:17] bit16 imm[15:0]
02241234
04462345
C8000000
06683456
20A5ABCD
0A8A4567
31F98765
C9000000
C0000008
DEAD0009
DEAD000A
0C1C5678
6123FEDC
C8000000
0E2E6789
71B70F0F
10407890
12528901
C0000004
DEAD0013
C0000000
14649012
21111111
16760123
C8000000
C8000000
18981234
60FF0000
1ABA2345
1CDC3456
C0000004
DEAD001F
